//--- src/id_macros.svh
`ifndef ID_MACROS_SVH
`define ID_MACROS_SVH

// data word and address width
`define ID_WORD_W 32

// register number width
`define ID_REG_ADDR_W 5

`define ID_NUM_SRC 2 // source operands per instruction

// JAL writes the return address here
`define ID_LINK_REG 31

`define ID_IMM_W 16 // immediate field of I-type words

`endif

//--- src/isa_pkg.sv
`default_nettype none

`include "id_macros.svh"

package isa_pkg;

    typedef logic [`ID_WORD_W-1:0]     word_t;
    typedef logic [`ID_REG_ADDR_W-1:0] reg_addr_t;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'b000000, // decoded further by funct
        OP_J       = 6'b000010,
        OP_JAL     = 6'b000011,
        OP_BEQ     = 6'b000100,
        OP_ADDI    = 6'b001000,
        OP_ADDIU   = 6'b001001,
        OP_ANDI    = 6'b001100,
        OP_ORI     = 6'b001101,
        OP_XORI    = 6'b001110,
        OP_LUI     = 6'b001111
    } opcode_t;

    typedef enum logic [5:0] {
        F_SLL  = 6'b000000,
        F_SRL  = 6'b000010,
        F_SRA  = 6'b000011,
        F_SLLV = 6'b000100,
        F_SRLV = 6'b000110,
        F_SRAV = 6'b000111,
        F_JR   = 6'b001000,
        F_JALR = 6'b001001,
        F_AND  = 6'b100100,
        F_OR   = 6'b100101,
        F_XOR  = 6'b100110,
        F_NOR  = 6'b100111
    } funct_t;

    // execute stage operation codes
    typedef enum logic [7:0] {
        ALU_NOP   = 8'b00000000,
        ALU_SRL   = 8'b00000010,
        ALU_SRA   = 8'b00000011,
        ALU_JR    = 8'b00001000,
        ALU_JALR  = 8'b00001001,
        ALU_AND   = 8'b00100100,
        ALU_OR    = 8'b00100101,
        ALU_XOR   = 8'b00100110,
        ALU_NOR   = 8'b00100111,
        ALU_J     = 8'b01001111,
        ALU_JAL   = 8'b01010000,
        ALU_BEQ   = 8'b01010001,
        ALU_ADDI  = 8'b01010101,
        ALU_ADDIU = 8'b01010110,
        ALU_SLL   = 8'b01111100
    } aluop_t;

    typedef enum logic [2:0] {
        SEL_NOP         = 3'b000,
        SEL_LOGIC       = 3'b001,
        SEL_SHIFT       = 3'b010,
        SEL_ARITH       = 3'b100,
        SEL_JUMP_BRANCH = 3'b110 // result is the link address
    } alusel_t;

endpackage

`default_nettype wire

//--- src/pipe_pkg.sv
`default_nettype none

`include "id_macros.svh"

package pipe_pkg;

    import isa_pkg::*;

    typedef struct packed {
        word_t pc;
        word_t inst;
    } fetch_pkt_t;

    // one forwarding or writeback source
    typedef struct packed {
        logic      wen;
        reg_addr_t addr;
        word_t     data;
    } fwd_t;

    typedef struct packed {
        aluop_t                       aluop;
        alusel_t                      alusel;
        logic [`ID_NUM_SRC-1:0]       read_en;  // bit 0 is rs, bit 1 is rt
        reg_addr_t [`ID_NUM_SRC-1:0]  src_addr;
        word_t                        imm;      // used where read_en is clear
        reg_addr_t                    dest;
        logic                         wen;
        logic                         invalid;
    } dec_ctrl_t;

    typedef struct packed {
        aluop_t    aluop;
        alusel_t   alusel;
        word_t     op1;
        word_t     op2;
        reg_addr_t dest;
        logic      wen;
        logic      branch_flag;
        word_t     branch_target;
        word_t     link_addr;
        logic      in_delay_slot;
        logic      invalid;
    } issue_pkt_t;

    typedef enum logic [1:0] {
        IDLE,      // ready to capture from fetch
        HOLD,      // issue request outstanding
        WAIT_DROP  // waiting for both acks to return low
    } stage_state_t;

endpackage

`default_nettype wire

//--- src/inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "id_macros.svh"

module inst_decoder
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  word_t     inst_i,
    output dec_ctrl_t ctrl_o
);

    opcode_t              opcode;
    funct_t               funct;
    reg_addr_t            rs;
    reg_addr_t            rt;
    reg_addr_t            rd;
    logic [4:0]           shamt;
    logic [`ID_IMM_W-1:0] imm16;

    assign opcode = opcode_t'(inst_i[31:26]);
    assign funct  = funct_t'(inst_i[5:0]);
    assign rs     = inst_i[25:21];
    assign rt     = inst_i[20:16];
    assign rd     = inst_i[15:11];
    assign shamt  = inst_i[10:6];
    assign imm16  = inst_i[`ID_IMM_W-1:0];

    always_comb begin
        ctrl_o.aluop       = ALU_NOP;
        ctrl_o.alusel      = SEL_NOP;
        ctrl_o.read_en     = '0;
        ctrl_o.src_addr[0] = rs;
        ctrl_o.src_addr[1] = rt;
        ctrl_o.imm         = '0;
        ctrl_o.dest        = rd; // rd unless overridden
        ctrl_o.wen         = 1'b0;
        ctrl_o.invalid     = 1'b1;

        case (opcode)
            OP_SPECIAL: begin
                ctrl_o.read_en = 2'b11;
                ctrl_o.wen     = 1'b1;
                ctrl_o.invalid = (shamt != '0); // register forms need zero shamt
                case (funct)
                    F_OR, F_AND, F_XOR, F_NOR: begin
                        ctrl_o.alusel = SEL_LOGIC;
                        ctrl_o.aluop  = (funct == F_OR)  ? ALU_OR  :
                                        (funct == F_AND) ? ALU_AND :
                                        (funct == F_XOR) ? ALU_XOR : ALU_NOR;
                    end
                    F_SLLV, F_SRLV, F_SRAV: begin
                        ctrl_o.alusel = SEL_SHIFT;
                        ctrl_o.aluop  = (funct == F_SLLV) ? ALU_SLL :
                                        (funct == F_SRLV) ? ALU_SRL : ALU_SRA;
                    end
                    F_SLL, F_SRL, F_SRA: begin
                        ctrl_o.alusel  = SEL_SHIFT;
                        ctrl_o.aluop   = (funct == F_SLL) ? ALU_SLL :
                                         (funct == F_SRL) ? ALU_SRL : ALU_SRA;
                        ctrl_o.read_en = 2'b10;  // only rt, op1 is shamt
                        ctrl_o.imm     = {{(`ID_WORD_W-5){1'b0}}, shamt};
                        ctrl_o.invalid = (rs != '0);
                    end
                    F_JR: begin
                        ctrl_o.aluop   = ALU_JR;
                        ctrl_o.alusel  = SEL_JUMP_BRANCH;
                        ctrl_o.read_en = 2'b01;
                        ctrl_o.wen     = 1'b0;
                    end
                    F_JALR: begin
                        ctrl_o.aluop   = ALU_JALR;
                        ctrl_o.alusel  = SEL_JUMP_BRANCH;
                        ctrl_o.read_en = 2'b01; // link goes to rd
                    end
                    default: begin
                        ctrl_o.invalid = 1'b1;
                    end
                endcase
            end
            OP_ORI, OP_ANDI, OP_XORI: begin
                ctrl_o.aluop   = (opcode == OP_ORI)  ? ALU_OR  :
                                 (opcode == OP_ANDI) ? ALU_AND : ALU_XOR;
                ctrl_o.alusel  = SEL_LOGIC;
                ctrl_o.read_en = 2'b01;
                ctrl_o.imm     = {{(`ID_WORD_W-`ID_IMM_W){1'b0}}, imm16}; // zero extend
                ctrl_o.dest    = rt;
                ctrl_o.wen     = 1'b1;
                ctrl_o.invalid = 1'b0;
            end
            OP_LUI: begin
                ctrl_o.aluop   = ALU_OR; // rs is r0 in a legal LUI
                ctrl_o.alusel  = SEL_LOGIC;
                ctrl_o.read_en = 2'b01;
                ctrl_o.imm     = {imm16, {(`ID_WORD_W-`ID_IMM_W){1'b0}}};
                ctrl_o.dest    = rt;
                ctrl_o.wen     = 1'b1;
                ctrl_o.invalid = 1'b0;
            end
            OP_ADDI, OP_ADDIU: begin
                ctrl_o.aluop   = (opcode == OP_ADDI) ? ALU_ADDI : ALU_ADDIU;
                ctrl_o.alusel  = SEL_ARITH;
                ctrl_o.read_en = 2'b01;
                ctrl_o.imm     = {{(`ID_WORD_W-`ID_IMM_W){imm16[`ID_IMM_W-1]}}, imm16};
                ctrl_o.dest    = rt;
                ctrl_o.wen     = 1'b1;
                ctrl_o.invalid = 1'b0;
            end
            OP_J: begin
                ctrl_o.aluop   = ALU_J;
                ctrl_o.alusel  = SEL_JUMP_BRANCH;
                ctrl_o.invalid = 1'b0;
            end
            OP_JAL: begin
                ctrl_o.aluop   = ALU_JAL;
                ctrl_o.alusel  = SEL_JUMP_BRANCH;
                ctrl_o.dest    = reg_addr_t'(`ID_LINK_REG);
                ctrl_o.wen     = 1'b1;
                ctrl_o.invalid = 1'b0;
            end
            OP_BEQ: begin
                ctrl_o.aluop   = ALU_BEQ;
                ctrl_o.alusel  = SEL_JUMP_BRANCH;
                ctrl_o.read_en = 2'b11; // compare rs with rt
                ctrl_o.invalid = 1'b0;
            end
            default: begin
            end
        endcase

        // unsupported words leave no side effects
        if (ctrl_o.invalid) begin
            ctrl_o.aluop   = ALU_NOP;
            ctrl_o.alusel  = SEL_NOP;
            ctrl_o.read_en = '0;
            ctrl_o.imm     = '0;
            ctrl_o.wen     = 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- src/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "id_macros.svh"

module reg_file
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  fwd_t                        wb_i,
    input  reg_addr_t [`ID_NUM_SRC-1:0] raddr_i,
    output word_t [`ID_NUM_SRC-1:0]     rdata_o
);

    localparam int NUM_REGS = 1 << `ID_REG_ADDR_W;

    word_t regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_i.wen) begin
            regs[wb_i.addr] <= wb_i.data;
        end
    end

    // read before write within a cycle
    always_comb begin
        for (int i = 0; i < `ID_NUM_SRC; i++) begin
            rdata_o[i] = regs[raddr_i[i]];
        end
    end

    wb_addr_known: assert property (
        @(posedge clk) disable iff (!rst_n_i) wb_i.wen |-> !$isunknown(wb_i.addr)
    ) else $error("writeback to unknown register address");

endmodule

`default_nettype wire

//--- src/operand_select.sv
`timescale 1ns/1ps
`default_nettype none

`include "id_macros.svh"

module operand_select
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic      read_en_i,
    input  reg_addr_t addr_i,
    input  word_t     imm_i,
    input  word_t     rf_data_i,
    input  fwd_t      ex_fwd_i,
    input  fwd_t      mem_fwd_i,
    output word_t     operand_o
);

    logic ex_hit;
    logic mem_hit;

    // newest producer first
    assign ex_hit  = ex_fwd_i.wen && (ex_fwd_i.addr == addr_i);
    assign mem_hit = mem_fwd_i.wen && (mem_fwd_i.addr == addr_i);

    always_comb begin
        if (!read_en_i) begin
            operand_o = imm_i; // immediate form
        end else if (ex_hit) begin
            operand_o = ex_fwd_i.data;
        end else if (mem_hit) begin
            operand_o = mem_fwd_i.data;
        end else begin
            operand_o = rf_data_i;
        end
    end

endmodule

`default_nettype wire

//--- src/branch_resolve.sv
`timescale 1ns/1ps
`default_nettype none

`include "id_macros.svh"

module branch_resolve
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  dec_ctrl_t               ctrl_i,
    input  word_t                   pc_i,
    input  word_t                   inst_i,
    input  word_t [`ID_NUM_SRC-1:0] op_i,
    output issue_pkt_t              pkt_o
);

    word_t pc_plus_4;
    word_t pc_plus_8;
    word_t jump_target;
    word_t beq_offset;

    assign pc_plus_4   = pc_i + word_t'(4);
    assign pc_plus_8   = pc_i + word_t'(8); // return past the delay slot
    assign jump_target = {pc_plus_4[31:28], inst_i[25:0], 2'b00};
    assign beq_offset  = {{(`ID_WORD_W-`ID_IMM_W-2){inst_i[`ID_IMM_W-1]}},
                          inst_i[`ID_IMM_W-1:0], 2'b00};

    always_comb begin
        pkt_o.aluop         = ctrl_i.aluop;
        pkt_o.alusel        = ctrl_i.alusel;
        pkt_o.op1           = op_i[0];
        pkt_o.op2           = op_i[1];
        pkt_o.dest          = ctrl_i.dest;
        pkt_o.wen           = ctrl_i.wen;
        pkt_o.branch_flag   = 1'b0;
        pkt_o.branch_target = '0;
        pkt_o.link_addr     = '0;
        pkt_o.in_delay_slot = 1'b0; // filled in by the stage
        pkt_o.invalid       = ctrl_i.invalid;

        case (ctrl_i.aluop)
            ALU_J, ALU_JAL: begin
                pkt_o.branch_flag   = 1'b1;
                pkt_o.branch_target = jump_target;
                pkt_o.link_addr     = (ctrl_i.aluop == ALU_JAL) ? pc_plus_8 : '0;
            end
            ALU_JR, ALU_JALR: begin
                pkt_o.branch_flag   = 1'b1;
                pkt_o.branch_target = op_i[0];
                pkt_o.link_addr     = (ctrl_i.aluop == ALU_JALR) ? pc_plus_8 : '0;
            end
            ALU_BEQ: begin
                if (op_i[0] == op_i[1]) begin
                    pkt_o.branch_flag   = 1'b1;
                    pkt_o.branch_target = pc_plus_4 + beq_offset;
                end
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

//--- src/id_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "id_macros.svh"

module id_stage
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n_i,
    input  logic       fetch_req_i,
    input  fetch_pkt_t fetch_pkt_i,
    output logic       fetch_ack_o,
    output logic       issue_req_o,
    output issue_pkt_t issue_pkt_o,
    input  logic       issue_ack_i,
    input  fwd_t       ex_fwd_i,
    input  fwd_t       mem_fwd_i,
    input  fwd_t       wb_i
);

    stage_state_t              state_q;
    logic                      fetch_ack_q;
    logic                      issue_req_q;
    logic                      delay_slot_q; // last captured packet branched
    issue_pkt_t                issue_pkt_q;
    dec_ctrl_t                 ctrl;
    word_t [`ID_NUM_SRC-1:0]   rf_data;
    word_t [`ID_NUM_SRC-1:0]   operand;
    issue_pkt_t                resolved_pkt;
    logic                      capture;

    inst_decoder u_decoder (
        .inst_i (fetch_pkt_i.inst),
        .ctrl_o (ctrl)
    );

    reg_file u_reg_file (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .wb_i    (wb_i),
        .raddr_i (ctrl.src_addr),
        .rdata_o (rf_data)
    );

    for (genvar i = 0; i < `ID_NUM_SRC; i++) begin : g_src
        operand_select u_opsel (
            .read_en_i (ctrl.read_en[i]),
            .addr_i    (ctrl.src_addr[i]),
            .imm_i     (ctrl.imm),
            .rf_data_i (rf_data[i]),
            .ex_fwd_i  (ex_fwd_i),
            .mem_fwd_i (mem_fwd_i),
            .operand_o (operand[i])
        );
    end

    branch_resolve u_branch (
        .ctrl_i (ctrl),
        .pc_i   (fetch_pkt_i.pc),
        .inst_i (fetch_pkt_i.inst),
        .op_i   (operand),
        .pkt_o  (resolved_pkt)
    );

    // single slot, so nothing new while the issue side is busy
    assign capture = (state_q == IDLE) && fetch_req_i && !fetch_ack_q &&
                     !issue_req_q && !issue_ack_i;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q      <= IDLE;
            fetch_ack_q  <= 1'b0;
            issue_req_q  <= 1'b0;
            delay_slot_q <= 1'b0;
        end else begin
            if (fetch_ack_q && !fetch_req_i) begin
                fetch_ack_q <= 1'b0;
            end
            if (issue_req_q && issue_ack_i) begin
                issue_req_q <= 1'b0;
            end
            case (state_q)
                IDLE: begin
                    if (capture) begin
                        fetch_ack_q  <= 1'b1;
                        issue_req_q  <= 1'b1;
                        delay_slot_q <= resolved_pkt.branch_flag;
                        state_q      <= HOLD;
                    end
                end
                HOLD: begin
                    if (issue_req_q && issue_ack_i) begin
                        state_q <= WAIT_DROP;
                    end
                end
                WAIT_DROP: begin
                    if (!issue_ack_i && !fetch_ack_q) begin
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            issue_pkt_q               <= resolved_pkt;
            issue_pkt_q.in_delay_slot <= delay_slot_q;
        end
    end

    assign fetch_ack_o = fetch_ack_q;
    assign issue_req_o = issue_req_q;
    assign issue_pkt_o = issue_pkt_q;

    issue_pkt_stable: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        issue_req_o && $past(issue_req_o) |-> $stable(issue_pkt_o)
    ) else $error("issue packet changed while request was high");

    fetch_ack_needs_req: assert property (
        @(posedge clk) disable iff (!rst_n_i) $rose(fetch_ack_o) |-> $past(fetch_req_i)
    ) else $error("fetch ack rose without a fetch request");

endmodule

`default_nettype wire

//--- dv/id_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "id_macros.svh"

module id_stage_tb
    import isa_pkg::*;
    import pipe_pkg::*;
();

    localparam int RESET_CYCLES    = 8;
    localparam int WORDS_PER_TEST  = 13; // tokens on one stimulus line
    localparam int MAX_TESTS       = 64;
    localparam int CYCLES_PER_TEST = 30;

    typedef logic [$bits(issue_pkt_t)-1:0] cmp_t; // wide enough for a whole packet

    logic        clk;
    logic        rst_n;
    logic        fetch_req;
    fetch_pkt_t  fetch_pkt;
    logic        fetch_ack;
    logic        issue_req;
    issue_pkt_t  issue_pkt;
    logic        issue_ack;
    fwd_t        ex_fwd;
    fwd_t        mem_fwd;
    fwd_t        wb;
    logic [31:0] stim [0:MAX_TESTS*WORDS_PER_TEST-1];
    int          num_tests;
    int          errors;
    int          tests_failed;
    bit          test_bad;
    bit          loaded;

    id_stage UUT (
        .clk         (clk),
        .rst_n_i     (rst_n),
        .fetch_req_i (fetch_req),
        .fetch_pkt_i (fetch_pkt),
        .fetch_ack_o (fetch_ack),
        .issue_req_o (issue_req),
        .issue_pkt_o (issue_pkt),
        .issue_ack_i (issue_ack),
        .ex_fwd_i    (ex_fwd),
        .mem_fwd_i   (mem_fwd),
        .wb_i        (wb)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk; // 4 ns period

    task automatic check_val(input string name, input cmp_t expected, input cmp_t actual);
        if (actual !== expected) begin
            $display("Error: %s expected %0h actual %0h", name, expected, actual);
            errors++;
            test_bad = 1'b1;
        end
    endtask

    // token holds enable in bit 8 and register number in bits 4:0
    function automatic fwd_t make_fwd(input logic [31:0] ctl, input logic [31:0] data);
        fwd_t f;
        f.wen  = ctl[8];
        f.addr = ctl[4:0];
        f.data = data;
        return f;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic run_test(input int t);
        int          base;
        int          delay;
        logic [31:0] exp_ctl;
        issue_pkt_t  held;
        base     = t * WORDS_PER_TEST;
        exp_ctl  = stim[base+8];
        test_bad = 1'b0;
        next_cycle();
        wb = make_fwd(stim[base], stim[base+1]);
        next_cycle();
        wb             = '0;
        ex_fwd         = make_fwd(stim[base+2], stim[base+3]);
        mem_fwd        = make_fwd(stim[base+4], stim[base+5]);
        fetch_pkt.pc   = stim[base+6];
        fetch_pkt.inst = stim[base+7];
        fetch_req      = 1'b1;
        next_cycle();
        // capture edge has just passed
        check_val("fetch_ack_o", cmp_t'(1'b1), cmp_t'(fetch_ack));
        check_val("issue_req_o", cmp_t'(1'b1), cmp_t'(issue_req));
        while (!fetch_ack) next_cycle();
        fetch_req = 1'b0;
        fetch_pkt = '0;
        ex_fwd    = '0; // late forwards must not reach the held packet
        mem_fwd   = '0;
        while (fetch_ack) next_cycle();
        while (!issue_req) next_cycle();
        held = issue_pkt;
        check_val("issue_pkt_o.aluop", cmp_t'(exp_ctl[23:16]), cmp_t'(issue_pkt.aluop));
        check_val("issue_pkt_o.alusel", cmp_t'(exp_ctl[14:12]), cmp_t'(issue_pkt.alusel));
        check_val("issue_pkt_o.op1", cmp_t'(stim[base+9]), cmp_t'(issue_pkt.op1));
        check_val("issue_pkt_o.op2", cmp_t'(stim[base+10]), cmp_t'(issue_pkt.op2));
        check_val("issue_pkt_o.dest", cmp_t'(exp_ctl[8:4]), cmp_t'(issue_pkt.dest));
        check_val("issue_pkt_o.wen", cmp_t'(exp_ctl[3]), cmp_t'(issue_pkt.wen));
        check_val("issue_pkt_o.branch_flag", cmp_t'(exp_ctl[2]),
                  cmp_t'(issue_pkt.branch_flag));
        check_val("issue_pkt_o.in_delay_slot", cmp_t'(exp_ctl[1]),
                  cmp_t'(issue_pkt.in_delay_slot));
        check_val("issue_pkt_o.invalid", cmp_t'(exp_ctl[0]), cmp_t'(issue_pkt.invalid));
        check_val("issue_pkt_o.branch_target", cmp_t'(stim[base+11]),
                  cmp_t'(issue_pkt.branch_target));
        check_val("issue_pkt_o.link_addr", cmp_t'(stim[base+12]),
                  cmp_t'(issue_pkt.link_addr));
        // execute holds off while a second fetch request waits
        delay          = $urandom_range(5, 0);
        fetch_pkt.pc   = stim[base+6] + 32'h8;
        fetch_pkt.inst = 32'h00221825;
        fetch_req      = (delay != 0);
        repeat (delay) begin
            next_cycle();
            check_val("fetch_ack_o", cmp_t'(1'b0), cmp_t'(fetch_ack));
            check_val("issue_pkt_o", cmp_t'(held), cmp_t'(issue_pkt));
        end
        issue_ack = 1'b1; // second request stays up through the ack
        while (issue_req) begin
            next_cycle();
            check_val("fetch_ack_o", cmp_t'(1'b0), cmp_t'(fetch_ack));
        end
        fetch_req = 1'b0;
        issue_ack = 1'b0;
        if (test_bad) begin
            tests_failed++;
        end
        $display("test %0d inst %h: %s", t + 1, stim[base+7], test_bad ? "fail" : "pass");
    endtask

    initial begin
        rst_n     = 1'b0;
        fetch_req = 1'b0;
        fetch_pkt = '0;
        issue_ack = 1'b0;
        ex_fwd    = '0;
        mem_fwd   = '0;
        wb        = '0;
        errors       = 0;
        tests_failed = 0;
        num_tests    = 0;
        test_bad     = 1'b0;
        loaded       = 1'b0;
        void'($urandom(32'hda62));
        for (int i = 0; i < MAX_TESTS * WORDS_PER_TEST; i++) begin
            stim[i] = '1; // marks slots the file leaves empty
        end
        $readmemh("dv/id_stimulus.txt", stim);
        while (num_tests < MAX_TESTS && stim[num_tests*WORDS_PER_TEST] != '1) begin
            num_tests++;
        end
        loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        if (num_tests == 0) begin
            $display("the stimulus file holds no tests");
            errors++;
        end
        for (int t = 0; t < num_tests; t++) begin
            run_test(t);
        end
        $display("tests run %0d, passed %0d, failed %0d, mismatches %0d",
                 num_tests, num_tests - tests_failed, tests_failed, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // watchdog
    initial begin
        wait (loaded);
        repeat (num_tests * CYCLES_PER_TEST + RESET_CYCLES + 4) @(posedge clk);
        $display("timeout: the stage stopped answering before all tests finished");
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/id_stimulus.txt
// wb wb_data ex ex_data mem mem_data pc inst ctl op1 op2 target link
// wb/ex/mem: bit 8 enable, bits 4:0 register; ctl: aluop, alusel, dest, {wen,br,ds,inv}
101 000000F0 000 00000000 000 00000000 00400000 00221825 251038 000000F0 00000000 00000000 00000000
102 0F0F0000 000 00000000 000 00000000 00400004 00222024 241048 000000F0 0F0F0000 00000000 00000000
105 FFFF0000 000 00000000 000 00000000 00400008 00A13026 261068 FFFF0000 000000F0 00000000 00000000
107 12345678 000 00000000 000 00000000 0040000C 00E54027 271088 12345678 FFFF0000 00000000 00000000
109 80000000 000 00000000 000 00000000 00400010 342A8001 2510A8 000000F0 00008001 00000000 00000000
10B 0000FFFF 000 00000000 000 00000000 00400014 316CF0F0 2410C8 0000FFFF 0000F0F0 00000000 00000000
000 00000000 000 00000000 000 00000000 00400018 38EDFFFF 2610D8 12345678 0000FFFF 00000000 00000000
000 00000000 000 00000000 000 00000000 0040001C 3C0EABCD 2510E8 00000000 ABCD0000 00000000 00000000
001 DEADBEEF 000 00000000 000 00000000 00400020 202FFFFC 5540F8 000000F0 FFFFFFFC 00000000 00000000
000 00000000 000 00000000 000 00000000 00400024 24F07FFF 564108 12345678 00007FFF 00000000 00000000
000 00000000 000 00000000 000 00000000 00400028 00078900 7C2118 00000004 12345678 00000000 00000000
000 00000000 000 00000000 000 00000000 0040002C 000997C3 032128 0000001F 80000000 00000000 00000000
000 00000000 000 00000000 000 00000000 00400030 00059A02 022138 00000008 FFFF0000 00000000 00000000
000 00000000 000 00000000 000 00000000 00400034 002BA004 7C2148 000000F0 0000FFFF 00000000 00000000
000 00000000 000 00000000 000 00000000 00400038 0047A806 022158 0F0F0000 12345678 00000000 00000000
000 00000000 000 00000000 000 00000000 0040003C 00A9B007 032168 FFFF0000 80000000 00000000 00000000
// forwarding priority
000 00000000 101 AAAAAAAA 101 BBBBBBBB 00400040 00221825 251038 AAAAAAAA 0F0F0000 00000000 00000000
000 00000000 105 11111111 102 22222222 00400044 00222024 241048 000000F0 22222222 00000000 00000000
000 00000000 001 CCCCCCCC 002 DDDDDDDD 00400048 00223026 261068 000000F0 0F0F0000 00000000 00000000
000 00000000 101 00000010 000 00000000 0040004C 202F0001 5540F8 00000010 00000001 00000000 00000000
// jumps, branches and delay slots
000 00000000 000 00000000 000 00000000 10000100 08123456 4F6064 00000000 00000000 1048D158 00000000
000 00000000 000 00000000 000 00000000 10000104 24300005 56410A 000000F0 00000005 00000000 00000000
000 00000000 000 00000000 000 00000000 00400020 0C100010 5061FC 00000000 00000000 00400040 00400028
000 00000000 000 00000000 000 00000000 00400100 00E00008 086006 12345678 00000000 12345678 00000000
000 00000000 000 00000000 000 00000000 00400200 0160F809 0961FE 0000FFFF 00000000 0000FFFF 00400208
000 00000000 000 00000000 102 000000F0 00400300 1022FFFE 5161F6 000000F0 000000F0 004002FC 00000000
000 00000000 000 00000000 000 00000000 00400310 10220010 516002 000000F0 0F0F0000 00000000 00000000
// unsupported words
000 00000000 000 00000000 000 00000000 00400314 0000000F 000001 00000000 00000000 00000000 00000000
000 00000000 000 00000000 000 00000000 00400318 8C220004 000001 00000000 00000000 00000000 00000000
000 00000000 000 00000000 000 00000000 0040031C 00001810 000031 00000000 00000000 00000000 00000000

//--- project.f
+incdir+src
src/isa_pkg.sv
src/pipe_pkg.sv
src/inst_decoder.sv
src/reg_file.sv
src/operand_select.sv
src/branch_resolve.sv
src/id_stage.sv
dv/id_stage_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --top-module id_stage_tb -f project.f \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/Vid_stage_tb > sim.log 2>&1 || echo "simulator exited with an error"
cat sim.log
grep -q "ERRORS FOUND" sim.log && { echo "FAIL"; exit 1; } || true
grep -q "NO ERRORS" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
